// ==== Makefile ====
# Verilator flow for the NTP server timing core

VERILATOR  ?= verilator
TOP        ?= tb_ntps_top
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= sim failed
PASS_MSG   ?= sim passed
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No pass message in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
src/ntps_time_pkg.sv
src/ntps_reg_pkg.sv
src/ntp_time_mux.sv
src/pps_test.sv
src/keymem.sv
src/ntps_regs.sv
src/ntps_top.sv
verif/ntps_top_assert.sv
verif/tb_ntps_top.sv

// ==== src/keymem.sv ====
`timescale 1ns/10ps

module keymem (
  input  logic                    sys_clk,
  input  logic                    rst,
  input  ntps_reg_pkg::key_wr_t   key_wr,
  input  ntps_reg_pkg::key_req_t  key_req,
  output ntps_reg_pkg::key_rsp_t  key_rsp
);

  import ntps_reg_pkg::*;

  // Word 0 sits in the low 32 bits of a key
  logic [KEY_WORDS-1:0][31:0] key_mem [NUM_KEYS];

  logic ack_q;
  key_t key_q;

  // --------------------------------------------------------------------------
  // Key table
  // --------------------------------------------------------------------------

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_KEYS; i++) begin
        key_mem[i] <= '0;
      end
    end else if (key_wr.we) begin
      key_mem[key_wr.id][key_wr.word] <= key_wr.data;
    end
  end

  // --------------------------------------------------------------------------
  // Key lookup
  // --------------------------------------------------------------------------

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= key_req.req;
    end
  end

  // Whole key read in one go, a write in the same cycle shows up later
  always_ff @(posedge sys_clk) begin
    if (key_req.req) begin
      key_q <= key_t'(key_mem[key_req.id]);
    end
  end

  assign key_rsp = '{ack: ack_q, key: key_q};

endmodule

// ==== src/ntp_time_mux.sv ====
`timescale 1ns/10ps

module ntp_time_mux (
  input  logic                      sys_clk,
  input  logic                      rst,
  input  ntps_time_pkg::ntp_stamp_t ntp_a,
  input  ntps_time_pkg::ntp_stamp_t ntp_b,
  input  logic                      pref_b,
  output ntps_time_pkg::ntp_stamp_t path_time,
  output logic                      sel_b
);

  import ntps_time_pkg::*;

  logic       want_b;
  ntp_stamp_t src;
  logic       upd_q;
  logic       sync_ok_q;
  ntp_time_t  time_q;

  // --------------------------------------------------------------------------
  // Source selection
  // --------------------------------------------------------------------------

  // Preferred source if it is in sync, else the other one if that is,
  // else fall back on the preferred source
  always_comb begin
    if (pref_b) begin
      want_b = ntp_b.sync_ok || !ntp_a.sync_ok;
    end else begin
      want_b = !ntp_a.sync_ok && ntp_b.sync_ok;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      sel_b <= 1'b0;
    end else begin
      sel_b <= want_b;
    end
  end

  // --------------------------------------------------------------------------
  // Time stamp capture
  // --------------------------------------------------------------------------

  assign src = sel_b ? ntp_b : ntp_a;

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      upd_q <= 1'b0;
    end else begin
      upd_q <= src.upd;
    end
  end

  // Time and sync state held until the next update
  always_ff @(posedge sys_clk) begin
    if (src.upd) begin
      time_q    <= src.ntp_time;
      sync_ok_q <= src.sync_ok;
    end
  end

  assign path_time = '{ntp_time: time_q, upd: upd_q, sync_ok: sync_ok_q};

endmodule

// ==== src/ntps_reg_pkg.sv ====
package ntps_reg_pkg;

  // --------------------------------------------------------------------------
  // Register bus
  // --------------------------------------------------------------------------

  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  typedef struct packed {
    logic      wr;
    logic      rd;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic      rvalid;
    reg_data_t rdata;
  } reg_rsp_t;

  // Address map
  localparam reg_addr_t ADDR_BUILD_INFO = 8'h00;
  localparam reg_addr_t ADDR_GIT_HASH   = 8'h01;
  localparam reg_addr_t ADDR_CTRL       = 8'h02;
  localparam reg_addr_t ADDR_STATUS     = 8'h03;
  localparam reg_addr_t KEY_BASE        = 8'h40;

  // Control and status layouts, bit 0 last
  typedef struct packed {
    logic led_en;
    logic pref_b;
  } ctrl_t;

  typedef struct packed {
    logic sel_b;
    logic sync_ok_b;
    logic sync_ok_a;
  } status_t;

  // --------------------------------------------------------------------------
  // Key memory
  // --------------------------------------------------------------------------

  localparam int KEY_WORDS  = 8;
  localparam int NUM_KEYS   = 4;
  localparam int KEY_WORD_W = $clog2(KEY_WORDS);
  localparam int KEY_WINDOW = NUM_KEYS * KEY_WORDS;

  typedef logic [$clog2(NUM_KEYS)-1:0] key_id_t;
  typedef logic [KEY_WORD_W-1:0]       key_word_t;
  typedef logic [255:0]                key_t;

  typedef struct packed {
    logic      we;
    key_id_t   id;
    key_word_t word;
    reg_data_t data;
  } key_wr_t;

  typedef struct packed {
    logic    req;
    key_id_t id;
  } key_req_t;

  typedef struct packed {
    logic ack;
    key_t key;
  } key_rsp_t;

endpackage

// ==== src/ntps_regs.sv ====
`timescale 1ns/10ps

module ntps_regs #(
  parameter ntps_reg_pkg::reg_data_t build_info = '0,
  parameter ntps_reg_pkg::reg_data_t git_hash   = '0
) (
  input  logic                   sys_clk,
  input  logic                   rst,
  input  ntps_reg_pkg::reg_req_t reg_req,
  output ntps_reg_pkg::reg_rsp_t reg_rsp,
  output logic                   ctrl_pref_b,
  output ntps_reg_pkg::key_wr_t  key_wr,
  input  logic                   sync_ok_a,
  input  logic                   sync_ok_b,
  input  logic                   sel_b,
  input  logic                   pps,
  output logic [7:0]             leds
);

  import ntps_reg_pkg::*;

  ctrl_t     ctrl_q;
  status_t   status;
  logic      in_key;
  reg_addr_t key_off;
  reg_data_t rdata_d;
  logic      rvalid_q;
  reg_data_t rdata_q;
  logic      key_we_q;
  key_id_t   key_id_q;
  key_word_t key_word_q;
  reg_data_t key_data_q;

  assign status  = '{sel_b: sel_b, sync_ok_b: sync_ok_b, sync_ok_a: sync_ok_a};
  assign in_key  = (reg_req.addr >= KEY_BASE) && (reg_req.addr < KEY_BASE + KEY_WINDOW);
  assign key_off = reg_req.addr - KEY_BASE;

  // --------------------------------------------------------------------------
  // Control register
  // --------------------------------------------------------------------------

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      ctrl_q <= '0;
    end else if (reg_req.wr && reg_req.addr == ADDR_CTRL) begin
      ctrl_q <= ctrl_t'(reg_req.wdata[$bits(ctrl_t)-1:0]);
    end
  end

  assign ctrl_pref_b = ctrl_q.pref_b;

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------

  // Key window is write only and falls into the default
  always_comb begin
    case (reg_req.addr)
      ADDR_BUILD_INFO: rdata_d = build_info;
      ADDR_GIT_HASH:   rdata_d = git_hash;
      ADDR_CTRL:       rdata_d = reg_data_t'(ctrl_q);
      ADDR_STATUS:     rdata_d = reg_data_t'(status);
      default:         rdata_d = '0;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= reg_req.rd;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reg_req.rd) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rsp = '{rvalid: rvalid_q, rdata: rdata_q};

  // --------------------------------------------------------------------------
  // Key word writes
  // --------------------------------------------------------------------------

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      key_we_q <= 1'b0;
    end else begin
      key_we_q <= reg_req.wr && in_key;
    end
  end

  // Key number above the word index in the window offset
  always_ff @(posedge sys_clk) begin
    key_id_q   <= key_off[KEY_WORD_W +: $bits(key_id_t)];
    key_word_q <= key_off[KEY_WORD_W-1:0];
    key_data_q <= reg_req.wdata;
  end

  assign key_wr = '{we: key_we_q, id: key_id_q, word: key_word_q, data: key_data_q};

  // Debug LEDs
  always_ff @(posedge sys_clk) begin
    if (rst || !ctrl_q.led_en) begin
      leds <= '0;
    end else begin
      leds <= {4'b0000, pps, status};
    end
  end

endmodule

// ==== src/ntps_time_pkg.sv ====
package ntps_time_pkg;

  // --------------------------------------------------------------------------
  // NTP time format
  // --------------------------------------------------------------------------

  // Seconds since the NTP epoch in the upper word, binary fraction below
  typedef struct packed {
    logic [31:0] seconds;
    logic [31:0] fraction;
  } ntp_time_t;

  // Time stamp as delivered by an NTP clock
  typedef struct packed {
    ntp_time_t ntp_time;
    logic      upd;
    logic      sync_ok;
  } ntp_stamp_t;

  // --------------------------------------------------------------------------
  // Test signal timing, in sys_clk cycles
  // --------------------------------------------------------------------------

  // One pulse per second at 200 MHz
  localparam int unsigned PPS_PERIOD_DEFAULT = 200_000_000;

  // Half period of the 10 MHz output
  localparam int unsigned TEN_MHZ_HALF = 10;

endpackage

// ==== src/ntps_top.sv ====
`timescale 1ns/10ps

module ntps_top #(
  parameter ntps_reg_pkg::reg_data_t build_info = '0,
  parameter ntps_reg_pkg::reg_data_t git_hash   = '0,
  parameter int unsigned             pps_period = ntps_time_pkg::PPS_PERIOD_DEFAULT
) (
  input  logic                      sys_clk,
  input  logic                      rst,
  input  ntps_time_pkg::ntp_stamp_t ntp_a,
  input  ntps_time_pkg::ntp_stamp_t ntp_b,
  input  ntps_reg_pkg::reg_req_t    reg_req,
  output ntps_reg_pkg::reg_rsp_t    reg_rsp,
  input  ntps_reg_pkg::key_req_t    key_req,
  output ntps_reg_pkg::key_rsp_t    key_rsp,
  output ntps_time_pkg::ntp_stamp_t path_time,
  output logic                      pps_out,
  output logic                      ten_mhz_out,
  output logic [7:0]                leds
);

  import ntps_reg_pkg::*;

  logic    ctrl_pref_b;
  logic    sel_b;
  key_wr_t key_wr;

  // --------------------------------------------------------------------------
  // Register block, steers the time mux and fills the key table
  // --------------------------------------------------------------------------
  ntps_regs #(
    .build_info (build_info),
    .git_hash   (git_hash)
  ) regs_0 (
    .sys_clk     (sys_clk),
    .rst         (rst),
    .reg_req     (reg_req),
    .reg_rsp     (reg_rsp),
    .ctrl_pref_b (ctrl_pref_b),
    .key_wr      (key_wr),
    .sync_ok_a   (ntp_a.sync_ok),
    .sync_ok_b   (ntp_b.sync_ok),
    .sel_b       (sel_b),
    .pps         (pps_out),
    .leds        (leds)
  );

  ntp_time_mux time_mux_0 (
    .sys_clk   (sys_clk),
    .rst       (rst),
    .ntp_a     (ntp_a),
    .ntp_b     (ntp_b),
    .pref_b    (ctrl_pref_b),
    .path_time (path_time),
    .sel_b     (sel_b)
  );

  keymem keymem_0 (
    .sys_clk (sys_clk),
    .rst     (rst),
    .key_wr  (key_wr),
    .key_req (key_req),
    .key_rsp (key_rsp)
  );

  // Test outputs
  pps_test #(
    .pps_period (pps_period)
  ) pps_test_0 (
    .sys_clk     (sys_clk),
    .rst         (rst),
    .pps_out     (pps_out),
    .ten_mhz_out (ten_mhz_out)
  );

endmodule

// ==== src/pps_test.sv ====
`timescale 1ns/10ps

module pps_test #(
  parameter int unsigned pps_period = ntps_time_pkg::PPS_PERIOD_DEFAULT
) (
  input  logic sys_clk,
  input  logic rst,
  output logic pps_out,
  output logic ten_mhz_out
);

  import ntps_time_pkg::*;

  localparam int PPS_W = $clog2(pps_period);
  localparam int TEN_W = $clog2(TEN_MHZ_HALF);

  logic [PPS_W-1:0] pps_cnt;
  logic [TEN_W-1:0] ten_cnt;

  // --------------------------------------------------------------------------
  // PPS pulse
  // --------------------------------------------------------------------------

  // One cycle wide, first pulse a full period after reset
  always_ff @(posedge sys_clk) begin
    if (rst) begin
      pps_cnt <= '0;
      pps_out <= 1'b0;
    end else if (pps_cnt == PPS_W'(pps_period - 1)) begin
      pps_cnt <= '0;
      pps_out <= 1'b1;
    end else begin
      pps_cnt <= pps_cnt + PPS_W'(1);
      pps_out <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // 10 MHz square wave
  // --------------------------------------------------------------------------

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      ten_cnt     <= '0;
      ten_mhz_out <= 1'b0;
    end else if (ten_cnt == TEN_W'(TEN_MHZ_HALF - 1)) begin
      ten_cnt     <= '0;
      ten_mhz_out <= !ten_mhz_out;
    end else begin
      ten_cnt <= ten_cnt + TEN_W'(1);
    end
  end

endmodule

// ==== verif/ntps_top_assert.sv ====
`timescale 1ns/10ps

module ntps_top_assert (
  input logic                      sys_clk,
  input logic                      rst,
  input ntps_reg_pkg::reg_req_t    reg_req,
  input ntps_reg_pkg::reg_rsp_t    reg_rsp,
  input ntps_reg_pkg::key_req_t    key_req,
  input ntps_reg_pkg::key_rsp_t    key_rsp,
  input ntps_time_pkg::ntp_stamp_t path_time,
  input logic                      sel_b,
  input logic                      ctrl_pref_b,
  input logic                      pps_out,
  input logic                      ten_mhz_out,
  input logic [7:0]                leds
);

  // --------------------------------------------------------------------------
  // Response timing
  // --------------------------------------------------------------------------

  rvalid_after_rd: assert property (@(posedge sys_clk) disable iff (rst)
    reg_rsp.rvalid == $past(reg_req.rd))
    else $error("register read response not exactly one cycle after rd");

  ack_after_req: assert property (@(posedge sys_clk) disable iff (rst)
    key_rsp.ack == $past(key_req.req))
    else $error("key ack not exactly one cycle after req");

  // Single cycle PPS pulse
  pps_one_cycle: assert property (@(posedge sys_clk) disable iff (rst)
    pps_out |=> !pps_out)
    else $error("pps pulse wider than one cycle");

  reset_outputs_low: assert property (@(posedge sys_clk)
    rst |=> (!reg_rsp.rvalid && !key_rsp.ack && !path_time.upd && !sel_b
             && !ctrl_pref_b && !pps_out && !ten_mhz_out && leds == 8'h00))
    else $error("outputs not low after a reset cycle");

endmodule

bind ntps_top ntps_top_assert assert_0 (
  .sys_clk     (sys_clk),
  .rst         (rst),
  .reg_req     (reg_req),
  .reg_rsp     (reg_rsp),
  .key_req     (key_req),
  .key_rsp     (key_rsp),
  .path_time   (path_time),
  .sel_b       (sel_b),
  .ctrl_pref_b (ctrl_pref_b),
  .pps_out     (pps_out),
  .ten_mhz_out (ten_mhz_out),
  .leds        (leds)
);

// ==== verif/tb_ntps_top.sv ====
`timescale 1ns/10ps

module tb_ntps_top;

  import ntps_time_pkg::*;
  import ntps_reg_pkg::*;

  localparam int        CLK_PERIOD = 10;
  localparam int        SEED       = 5890;
  localparam int        PPS_PERIOD = 1000;
  localparam reg_data_t BUILD_INFO = 32'h0107_0300;
  localparam reg_data_t GIT_HASH   = 32'h5e3a_91c7;

  // Cycles per test phase
  localparam int RST_CYCLES    = 2;
  localparam int REG_CYCLES    = 300;
  localparam int KEY_WR_CYCLES = 64;
  localparam int KEY_RD_CYCLES = 100;
  localparam int MUX_CYCLES    = 2000;
  localparam int DRAIN_CYCLES  = 4;
  localparam int TEST_CYCLES   = RST_CYCLES + REG_CYCLES + KEY_WR_CYCLES
                                 + KEY_RD_CYCLES + MUX_CYCLES + DRAIN_CYCLES;
  localparam int WATCHDOG_NS   = TEST_CYCLES * CLK_PERIOD + 2000;

  logic       sys_clk;
  logic       rst;
  ntp_stamp_t ntp_a;
  ntp_stamp_t ntp_b;
  reg_req_t   reg_req;
  reg_rsp_t   reg_rsp;
  key_req_t   key_req;
  key_rsp_t   key_rsp;
  ntp_stamp_t path_time;
  logic       pps_out;
  logic       ten_mhz_out;
  logic [7:0] leds;

  // Reference model state after the coming clock edge
  logic [1:0] m_ctrl;
  key_t       m_keys [NUM_KEYS];
  key_wr_t    m_kw;
  logic       m_sel_b;
  int         m_cyc;

  // Expected outputs after the coming clock edge
  logic       e_rvalid;
  reg_data_t  e_rdata;
  logic       e_ack;
  key_t       e_key;
  logic       e_upd;
  ntp_time_t  e_time;
  logic       e_sync;
  logic       e_pps;
  logic       e_ten;
  logic [7:0] e_leds;

  logic check_en = 1'b0;
  int   n_pps    = 0;
  int   n_upd    = 0;
  int   n_ack    = 0;
  int   n_led    = 0;

  ntps_top #(
    .build_info (BUILD_INFO),
    .git_hash   (GIT_HASH),
    .pps_period (PPS_PERIOD)
  ) dut (
    .sys_clk     (sys_clk),
    .rst         (rst),
    .ntp_a       (ntp_a),
    .ntp_b       (ntp_b),
    .reg_req     (reg_req),
    .reg_rsp     (reg_rsp),
    .key_req     (key_req),
    .key_rsp     (key_rsp),
    .path_time   (path_time),
    .pps_out     (pps_out),
    .ten_mhz_out (ten_mhz_out),
    .leds        (leds)
  );

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  // --------------------------------------------------------------------------
  // Checking and model rules
  // --------------------------------------------------------------------------

  task automatic check_eq(input logic [255:0] actual, input logic [255:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s mismatch, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("sim failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Preferred source when in sync, else the other one when in sync
  function automatic logic select_b(input logic pref_b, input logic ok_a, input logic ok_b);
    logic ok_pref;
    logic ok_other;
    ok_pref  = pref_b ? ok_b : ok_a;
    ok_other = pref_b ? ok_a : ok_b;
    if (ok_pref) begin
      return pref_b;
    end else if (ok_other) begin
      return !pref_b;
    end
    return pref_b;
  endfunction

  function automatic reg_data_t read_value(input reg_addr_t addr, input logic [1:0] ctrl,
                                           input logic [2:0] status);
    reg_data_t v;
    v = '0;
    if (addr == ADDR_BUILD_INFO) begin
      v = BUILD_INFO;
    end else if (addr == ADDR_GIT_HASH) begin
      v = GIT_HASH;
    end else if (addr == ADDR_CTRL) begin
      v = {30'd0, ctrl};
    end else if (addr == ADDR_STATUS) begin
      v = {29'd0, status};
    end
    return v;
  endfunction

  task automatic compare_outputs();
    check_eq(reg_rsp.rvalid, e_rvalid, "rvalid");
    if (e_rvalid) begin
      check_eq(reg_rsp.rdata, e_rdata, "rdata");
    end
    check_eq(key_rsp.ack, e_ack, "key ack");
    if (e_ack) begin
      check_eq(key_rsp.key, e_key, "key");
    end
    check_eq(path_time.upd, e_upd, "path_time upd");
    if (e_upd) begin
      check_eq(path_time.ntp_time, e_time, "path_time time");
      check_eq(path_time.sync_ok, e_sync, "path_time sync_ok");
    end
    check_eq(pps_out, e_pps, "pps_out");
    check_eq(ten_mhz_out, e_ten, "ten_mhz_out");
    check_eq(leds, e_leds, "leds");
    if (pps_out) n_pps++;
    if (path_time.upd) n_upd++;
    if (key_rsp.ack) n_ack++;
    if (leds != 8'h00) n_led++;
  endtask

  // Steps the model over the coming edge with the inputs now applied
  task automatic advance_model();
    logic [2:0] status;
    ntp_stamp_t src;
    int         off;
    if (rst) begin
      m_ctrl   = '0;
      m_kw     = '0;
      m_sel_b  = 1'b0;
      m_cyc    = 0;
      e_rvalid = 1'b0;
      e_ack    = 1'b0;
      e_upd    = 1'b0;
      e_pps    = 1'b0;
      e_ten    = 1'b0;
      e_leds   = '0;
      for (int i = 0; i < NUM_KEYS; i++) begin
        m_keys[i] = '0;
      end
    end else begin
      status   = {m_sel_b, ntp_b.sync_ok, ntp_a.sync_ok};
      e_rvalid = reg_req.rd;
      if (reg_req.rd) begin
        e_rdata = read_value(reg_req.addr, m_ctrl, status);
      end
      e_leds = m_ctrl[1] ? {4'b0000, e_pps, status} : 8'h00;

      // Lookup sees the table before the pending word lands
      e_ack = key_req.req;
      if (key_req.req) begin
        e_key = m_keys[key_req.id];
      end
      if (m_kw.we) begin
        m_keys[m_kw.id][int'(m_kw.word) * 32 +: 32] = m_kw.data;
      end
      off     = int'(reg_req.addr) - int'(KEY_BASE);
      m_kw.we = reg_req.wr && off >= 0 && off < NUM_KEYS * KEY_WORDS;
      if (m_kw.we) begin
        m_kw.id   = key_id_t'(off / KEY_WORDS);
        m_kw.word = key_word_t'(off % KEY_WORDS);
        m_kw.data = reg_req.wdata;
      end

      src   = m_sel_b ? ntp_b : ntp_a;
      e_upd = src.upd;
      if (src.upd) begin
        e_time = src.ntp_time;
        e_sync = src.sync_ok;
      end
      m_sel_b = select_b(m_ctrl[0], ntp_a.sync_ok, ntp_b.sync_ok);
      if (reg_req.wr && reg_req.addr == ADDR_CTRL) begin
        m_ctrl = reg_req.wdata[1:0];
      end

      m_cyc++;
      e_pps = (m_cyc % PPS_PERIOD) == 0;
      e_ten = ((m_cyc / TEN_MHZ_HALF) % 2) == 1;
    end
  endtask

  always @(negedge sys_clk) begin
    if (check_en) begin
      compare_outputs();
    end
    advance_model();
    check_en = 1'b1;
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  function automatic ntp_stamp_t next_stamp(input ntp_stamp_t cur);
    ntp_stamp_t s;
    s.ntp_time.seconds  = $urandom;
    s.ntp_time.fraction = $urandom;
    s.upd               = ($urandom % 3) == 0;
    // Sync levels hold for a while
    s.sync_ok           = (($urandom % 8) == 0) ? !cur.sync_ok : cur.sync_ok;
    return s;
  endfunction

  function automatic reg_req_t random_access();
    reg_req_t    r;
    int unsigned kind;
    r       = '0;
    kind    = $urandom % 8;
    r.wdata = $urandom;
    case (kind)
      0:       r.addr = ADDR_BUILD_INFO;
      1:       r.addr = ADDR_GIT_HASH;
      2, 3:    r.addr = ADDR_CTRL;
      4:       r.addr = ADDR_STATUS;
      5:       r.addr = KEY_BASE + reg_addr_t'($urandom % (NUM_KEYS * KEY_WORDS));
      6:       r.addr = reg_addr_t'(8'h04 + $urandom % 60);
      default: r.addr = reg_addr_t'(8'h60 + $urandom % 160);
    endcase
    r.wr = (kind == 2);
    r.rd = (kind != 2);
    return r;
  endfunction

  function automatic reg_req_t key_write();
    reg_req_t r;
    r       = '0;
    r.wr    = 1'b1;
    r.addr  = KEY_BASE + reg_addr_t'($urandom % (NUM_KEYS * KEY_WORDS));
    r.wdata = $urandom;
    return r;
  endfunction

  function automatic key_req_t key_lookup();
    key_req_t k;
    k.req = ($urandom % 4) != 0;
    k.id  = key_id_t'($urandom % NUM_KEYS);
    return k;
  endfunction

  // Occasional CTRL writes, some STATUS reads
  function automatic reg_req_t ctrl_or_status();
    reg_req_t    r;
    int unsigned kind;
    r       = '0;
    kind    = $urandom % 16;
    r.wdata = $urandom;
    if (kind == 0) begin
      r.wr   = 1'b1;
      r.addr = ADDR_CTRL;
    end else if (kind < 5) begin
      r.rd   = 1'b1;
      r.addr = ADDR_STATUS;
    end
    return r;
  endfunction

  task automatic drive_cycle(input reg_req_t req, input key_req_t kreq);
    @(posedge sys_clk);
    reg_req <= req;
    key_req <= kreq;
    ntp_a   <= next_stamp(ntp_a);
    ntp_b   <= next_stamp(ntp_b);
  endtask

  initial begin
    void'($urandom(SEED));
    rst       = 1'b1;
    ntp_a     = '0;
    ntp_b     = '0;
    reg_req   = '0;
    key_req   = '0;
    repeat (RST_CYCLES) @(posedge sys_clk);
    rst <= 1'b0;

    for (int i = 0; i < REG_CYCLES; i++) begin
      drive_cycle(random_access(), '0);
    end
    for (int i = 0; i < KEY_WR_CYCLES; i++) begin
      drive_cycle(key_write(), '0);
    end
    for (int i = 0; i < KEY_RD_CYCLES; i++) begin
      drive_cycle('0, key_lookup());
    end
    for (int i = 0; i < MUX_CYCLES; i++) begin
      drive_cycle(ctrl_or_status(), '0);
    end
    for (int i = 0; i < DRAIN_CYCLES; i++) begin
      drive_cycle('0, '0);
    end

    check_eq(n_pps >= 2, 1'b1, "pps pulse count");
    check_eq(n_upd != 0, 1'b1, "path_time update count");
    check_eq(n_ack != 0, 1'b1, "key ack count");
    check_eq(n_led != 0, 1'b1, "lit led count");
    $display("sim passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test sequence finished");
    $display("sim failed");
    $fatal(1, "watchdog");
  end

endmodule
